//--- rtl/core_pkg.sv
// Core machine widths
package core_pkg;

    ////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////

    localparam int XLEN = 32;   // operand and result width.

    ////////////////////////////////////////////////////////////////////
    // tags
    ////////////////////////////////////////////////////////////////////

    localparam int TAG_W = 3;

    // On a destination this means no write, on a source it means the
    // value field already holds the operand.
    localparam logic [TAG_W-1:0] TAG_NONE = '0;

endpackage

//--- rtl/alu_op_pkg.sv
// ALU op code encoding
package alu_op_pkg;

    localparam int OP_W = 5;

    ////////////////////////////////////////////////////////////////////
    // arithmetic, logic and shifts
    ////////////////////////////////////////////////////////////////////

    localparam logic [OP_W-1:0] ADD  = 5'b00000;
    localparam logic [OP_W-1:0] AND  = 5'b00001;
    localparam logic [OP_W-1:0] OR   = 5'b00010;
    localparam logic [OP_W-1:0] SLL  = 5'b00011;
    localparam logic [OP_W-1:0] SRL  = 5'b00100;
    localparam logic [OP_W-1:0] SLT  = 5'b00101;   // signed.
    localparam logic [OP_W-1:0] SLTU = 5'b00110;
    localparam logic [OP_W-1:0] SRA  = 5'b00111;
    localparam logic [OP_W-1:0] SUB  = 5'b01000;
    localparam logic [OP_W-1:0] XOR  = 5'b01001;

    ////////////////////////////////////////////////////////////////////
    // branch compares and jump target
    ////////////////////////////////////////////////////////////////////

    // compares give a plain 0/1, nothing is redirected here.
    localparam logic [OP_W-1:0] EQ   = 5'b01010;
    localparam logic [OP_W-1:0] GE   = 5'b01011;   // signed.
    localparam logic [OP_W-1:0] NE   = 5'b01100;
    localparam logic [OP_W-1:0] GEU  = 5'b01101;
    localparam logic [OP_W-1:0] JALR = 5'b10001;   // plain add of both operands.
    localparam logic [OP_W-1:0] LT   = 5'b11010;   // signed.
    localparam logic [OP_W-1:0] LTU  = 5'b11011;

    // Codes not listed above are legal to dispatch and produce zero.

endpackage

//--- rtl/alu_station.sv
// ALU reservation station
`timescale 1ns/1ps

module alu_station #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        disp_valid,
    input  logic [alu_op_pkg::OP_W-1:0] disp_op,
    input  logic [core_pkg::TAG_W-1:0]  disp_dest,
    input  logic [core_pkg::TAG_W-1:0]  disp_src1_tag,
    input  logic [core_pkg::XLEN-1:0]   disp_src1_value,
    input  logic [core_pkg::TAG_W-1:0]  disp_src2_tag,
    input  logic [core_pkg::XLEN-1:0]   disp_src2_value,
    input  logic                        cdb_valid,
    input  logic [core_pkg::TAG_W-1:0]  cdb_tag,
    input  logic [core_pkg::XLEN-1:0]   cdb_value,
    input  logic                        ext_valid,
    input  logic [core_pkg::TAG_W-1:0]  ext_tag,
    input  logic [core_pkg::XLEN-1:0]   ext_value,
    output logic                        full,
    output logic                        issue_valid,
    output logic [alu_op_pkg::OP_W-1:0] issue_op,
    output logic [core_pkg::TAG_W-1:0]  issue_dest,
    output logic [core_pkg::XLEN-1:0]   issue_value1,
    output logic [core_pkg::XLEN-1:0]   issue_value2
);

    localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
    localparam int ROWS  = NUM_ENTRIES + 1;   // stored entries plus dispatch row.

    logic [NUM_ENTRIES-1:0]      entry_valid;
    logic [NUM_ENTRIES-1:0]      entry_ready;
    logic [alu_op_pkg::OP_W-1:0] entry_op   [NUM_ENTRIES];
    logic [core_pkg::TAG_W-1:0]  entry_dest [NUM_ENTRIES];
    logic [core_pkg::TAG_W-1:0]  src_tag    [NUM_ENTRIES][2];
    logic [core_pkg::XLEN-1:0]   src_value  [NUM_ENTRIES][2];

    logic [core_pkg::TAG_W-1:0]  cur_tag    [ROWS][2];
    logic [core_pkg::XLEN-1:0]   cur_value  [ROWS][2];
    logic [core_pkg::TAG_W-1:0]  nxt_tag    [ROWS][2];
    logic [core_pkg::XLEN-1:0]   nxt_value  [ROWS][2];

    logic [IDX_W-1:0]            free_idx;
    logic [IDX_W-1:0]            issue_idx;
    logic                        disp_take;

    function automatic logic bus_hit(
        input logic                       bus_valid,
        input logic [core_pkg::TAG_W-1:0] bus_tag,
        input logic [core_pkg::TAG_W-1:0] wait_tag
    );
        return bus_valid && (wait_tag != core_pkg::TAG_NONE) && (wait_tag == bus_tag);
    endfunction

    ////////////////////////////////////////////////////////////////////
    // operand wake-up
    ////////////////////////////////////////////////////////////////////

    // The last row is the operation being dispatched, so a result that
    // shows up in the dispatch cycle is not missed.
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            for (int k = 0; k < 2; k++) begin
                cur_tag[i][k]   = src_tag[i][k];
                cur_value[i][k] = src_value[i][k];
            end
        end
        cur_tag[NUM_ENTRIES][0]   = disp_src1_tag;
        cur_value[NUM_ENTRIES][0] = disp_src1_value;
        cur_tag[NUM_ENTRIES][1]   = disp_src2_tag;
        cur_value[NUM_ENTRIES][1] = disp_src2_value;

        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < 2; k++) begin
                nxt_tag[r][k]   = cur_tag[r][k];
                nxt_value[r][k] = cur_value[r][k];
                if (bus_hit(cdb_valid, cdb_tag, cur_tag[r][k])) begin
                    nxt_tag[r][k]   = core_pkg::TAG_NONE;
                    nxt_value[r][k] = cdb_value;
                end else if (bus_hit(ext_valid, ext_tag, cur_tag[r][k])) begin
                    nxt_tag[r][k]   = core_pkg::TAG_NONE;
                    nxt_value[r][k] = ext_value;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // free and issue select
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            entry_ready[i] = entry_valid[i] &&
                             (src_tag[i][0] == core_pkg::TAG_NONE) &&
                             (src_tag[i][1] == core_pkg::TAG_NONE);
        end
    end

    always_comb begin
        free_idx  = '0;
        issue_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin   // lowest index wins.
            if (!entry_valid[i]) begin
                free_idx = IDX_W'(i);
            end
            if (entry_ready[i]) begin
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign full         = &entry_valid;
    assign disp_take    = disp_valid && !full;   // strobe while full is dropped.
    assign issue_valid  = |entry_ready;
    assign issue_op     = entry_op[issue_idx];
    assign issue_dest   = entry_dest[issue_idx];
    assign issue_value1 = src_value[issue_idx][0];
    assign issue_value2 = src_value[issue_idx][1];

    ////////////////////////////////////////////////////////////////////
    // entry state
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            entry_valid <= '0;
        end else begin
            if (issue_valid) begin
                entry_valid[issue_idx] <= 1'b0;
            end
            if (disp_take) begin
                entry_valid[free_idx] <= 1'b1;   // never the issuing entry.
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            for (int k = 0; k < 2; k++) begin
                src_tag[i][k]   <= nxt_tag[i][k];
                src_value[i][k] <= nxt_value[i][k];
            end
        end
        if (disp_take) begin
            entry_op[free_idx]   <= disp_op;
            entry_dest[free_idx] <= disp_dest;
            for (int k = 0; k < 2; k++) begin
                src_tag[free_idx][k]   <= nxt_tag[NUM_ENTRIES][k];
                src_value[free_idx][k] <= nxt_value[NUM_ENTRIES][k];
            end
        end
    end

endmodule

//--- rtl/alu_datapath.sv
// Registered ALU stage
`timescale 1ns/1ps

module alu_datapath (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue_valid,
    input  logic [alu_op_pkg::OP_W-1:0] issue_op,
    input  logic [core_pkg::TAG_W-1:0]  issue_dest,
    input  logic [core_pkg::XLEN-1:0]   issue_value1,
    input  logic [core_pkg::XLEN-1:0]   issue_value2,
    output logic                        alu_valid,
    output logic [core_pkg::TAG_W-1:0]  alu_dest,
    output logic [core_pkg::XLEN-1:0]   alu_result
);

    localparam int XW = core_pkg::XLEN;

    logic [4:0]    shamt;
    logic          lt_s;
    logic          lt_u;
    logic          eq;
    logic [XW-1:0] result;

    assign shamt = issue_value2[4:0];
    assign lt_s  = $signed(issue_value1) < $signed(issue_value2);
    assign lt_u  = issue_value1 < issue_value2;
    assign eq    = issue_value1 == issue_value2;

    ////////////////////////////////////////////////////////////////////
    // op decode
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (issue_op)
            alu_op_pkg::ADD:  result = issue_value1 + issue_value2;
            alu_op_pkg::JALR: result = issue_value1 + issue_value2;
            alu_op_pkg::SUB:  result = issue_value1 - issue_value2;
            alu_op_pkg::AND:  result = issue_value1 & issue_value2;
            alu_op_pkg::OR:   result = issue_value1 | issue_value2;
            alu_op_pkg::XOR:  result = issue_value1 ^ issue_value2;
            alu_op_pkg::SLL:  result = issue_value1 << shamt;
            alu_op_pkg::SRL:  result = issue_value1 >> shamt;
            alu_op_pkg::SRA:  result = $unsigned($signed(issue_value1) >>> shamt);
            alu_op_pkg::SLT:  result = {{(XW-1){1'b0}}, lt_s};
            alu_op_pkg::LT:   result = {{(XW-1){1'b0}}, lt_s};
            alu_op_pkg::SLTU: result = {{(XW-1){1'b0}}, lt_u};
            alu_op_pkg::LTU:  result = {{(XW-1){1'b0}}, lt_u};
            alu_op_pkg::GE:   result = {{(XW-1){1'b0}}, !lt_s};
            alu_op_pkg::GEU:  result = {{(XW-1){1'b0}}, !lt_u};
            alu_op_pkg::EQ:   result = {{(XW-1){1'b0}}, eq};
            alu_op_pkg::NE:   result = {{(XW-1){1'b0}}, !eq};
            default:          result = '0;   // unused codes.
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        alu_dest   <= issue_dest;
        alu_result <= result;
    end

endmodule

//--- rtl/cdb_writer.sv
// Result bus writer
`timescale 1ns/1ps

module cdb_writer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       alu_valid,
    input  logic [core_pkg::TAG_W-1:0] alu_dest,
    input  logic [core_pkg::XLEN-1:0]  alu_result,
    output logic                       cdb_valid,
    output logic [core_pkg::TAG_W-1:0] cdb_tag,
    output logic [core_pkg::XLEN-1:0]  cdb_value
);

    logic broadcast;

    // A do-nothing operation still went through the ALU but is not
    // announced, so no waiting operand can match on tag zero.
    assign broadcast = alu_valid && (alu_dest != core_pkg::TAG_NONE);

    ////////////////////////////////////////////////////////////////////
    // bus register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= broadcast;   // one cycle pulse per result.
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag   <= alu_dest;
        cdb_value <= alu_result;
    end

endmodule

//--- rtl/alu_exec_unit.sv
// Integer execution cluster
`timescale 1ns/1ps

module alu_exec_unit #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        disp_valid,
    input  logic [alu_op_pkg::OP_W-1:0] disp_op,
    input  logic [core_pkg::TAG_W-1:0]  disp_dest,
    input  logic [core_pkg::TAG_W-1:0]  disp_src1_tag,
    input  logic [core_pkg::XLEN-1:0]   disp_src1_value,
    input  logic [core_pkg::TAG_W-1:0]  disp_src2_tag,
    input  logic [core_pkg::XLEN-1:0]   disp_src2_value,
    input  logic                        ext_valid,
    input  logic [core_pkg::TAG_W-1:0]  ext_tag,
    input  logic [core_pkg::XLEN-1:0]   ext_value,
    output logic                        full,
    output logic                        cdb_valid,
    output logic [core_pkg::TAG_W-1:0]  cdb_tag,
    output logic [core_pkg::XLEN-1:0]   cdb_value
);

    logic                        issue_valid;
    logic [alu_op_pkg::OP_W-1:0] issue_op;
    logic [core_pkg::TAG_W-1:0]  issue_dest;
    logic [core_pkg::XLEN-1:0]   issue_value1;
    logic [core_pkg::XLEN-1:0]   issue_value2;

    logic                        alu_valid;
    logic [core_pkg::TAG_W-1:0]  alu_dest;
    logic [core_pkg::XLEN-1:0]   alu_result;

    ////////////////////////////////////////////////////////////////////
    // station, ALU, bus writer
    ////////////////////////////////////////////////////////////////////

    alu_station #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) i_station (
        .clk            (clk),
        .rst            (rst),
        .disp_valid     (disp_valid),
        .disp_op        (disp_op),
        .disp_dest      (disp_dest),
        .disp_src1_tag  (disp_src1_tag),
        .disp_src1_value(disp_src1_value),
        .disp_src2_tag  (disp_src2_tag),
        .disp_src2_value(disp_src2_value),
        .cdb_valid      (cdb_valid),   // own bus fed back.
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .ext_valid      (ext_valid),
        .ext_tag        (ext_tag),
        .ext_value      (ext_value),
        .full           (full),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_dest     (issue_dest),
        .issue_value1   (issue_value1),
        .issue_value2   (issue_value2)
    );

    alu_datapath i_datapath (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_dest  (issue_dest),
        .issue_value1(issue_value1),
        .issue_value2(issue_value2),
        .alu_valid   (alu_valid),
        .alu_dest    (alu_dest),
        .alu_result  (alu_result)
    );

    cdb_writer i_writer (
        .clk       (clk),
        .rst       (rst),
        .alu_valid (alu_valid),
        .alu_dest  (alu_dest),
        .alu_result(alu_result),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value)
    );

endmodule

//--- tests/alu_exec_props.sv
// Execution cluster properties
`timescale 1ns/1ps

module alu_exec_props (
    input logic                       clk,
    input logic                       rst,
    input logic                       disp_valid,
    input logic                       full,
    input logic                       cdb_valid,
    input logic [core_pkg::TAG_W-1:0] cdb_tag
);

    // do-nothing operations never reach the bus.
    no_tag_none: assert property (@(posedge clk) disable iff (!rst)
        cdb_valid |-> (cdb_tag != core_pkg::TAG_NONE))
        else $error("result bus valid with tag zero");

    reset_clears_bus: assert property (@(posedge clk) !rst |=> !cdb_valid)
        else $error("result bus valid in the cycle after reset");

    no_dispatch_when_full: assert property (@(posedge clk) disable iff (!rst)
        !(disp_valid && full))
        else $error("dispatch strobe while the station is full");

endmodule

bind alu_exec_unit alu_exec_props i_props (
    .clk       (clk),
    .rst       (rst),
    .disp_valid(disp_valid),
    .full      (full),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag)
);

//--- tests/tb_alu_exec.sv
// Execution cluster testbench
`timescale 1ns/1ps

module tb_alu_exec;

    localparam int XW    = core_pkg::XLEN;
    localparam int TW    = core_pkg::TAG_W;
    localparam int OW    = alu_op_pkg::OP_W;
    localparam int NTAG  = 1 << TW;
    localparam int LIMIT = 200;   // cycles per wait.

    logic          clk;
    logic          rst;
    logic          disp_valid;
    logic [OW-1:0] disp_op;
    logic [TW-1:0] disp_dest;
    logic [TW-1:0] disp_src1_tag;
    logic [XW-1:0] disp_src1_value;
    logic [TW-1:0] disp_src2_tag;
    logic [XW-1:0] disp_src2_value;
    logic          ext_valid;
    logic [TW-1:0] ext_tag;
    logic [XW-1:0] ext_value;
    logic          full;
    logic          cdb_valid;
    logic [TW-1:0] cdb_tag;
    logic [XW-1:0] cdb_value;

    logic          pend       [NTAG];   // scoreboard, one slot per tag.
    logic          known      [NTAG];
    logic [OW-1:0] pend_op    [NTAG];
    logic [TW-1:0] wait_tag   [NTAG][2];
    logic [XW-1:0] opnd       [NTAG][2];
    logic [XW-1:0] expect_v   [NTAG];
    int            disp_cycle [NTAG];
    int            done_cycle [NTAG];
    int            cycle;
    int            checks;
    int            errors;
    int            tests;

    alu_exec_unit #(.NUM_ENTRIES(4)) i_dut (.*);

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////

    function automatic logic [XW-1:0] expected_result(
        input logic [OW-1:0] op,
        input logic [XW-1:0] a,
        input logic [XW-1:0] b
    );
        logic [XW-1:0] fill;
        logic [XW-1:0] r;
        logic          lt_s;
        logic          lt_u;
        lt_u = a < b;
        lt_s = {~a[XW-1], a[XW-2:0]} < {~b[XW-1], b[XW-2:0]};   // offset binary.
        fill = a[XW-1] ? ~({XW{1'b1}} >> b[4:0]) : '0;
        case (op)
            alu_op_pkg::ADD, alu_op_pkg::JALR: r = a + b;
            alu_op_pkg::SUB:                   r = a - b;
            alu_op_pkg::AND:                   r = a & b;
            alu_op_pkg::OR:                    r = a | b;
            alu_op_pkg::XOR:                   r = a ^ b;
            alu_op_pkg::SLL:                   r = a << b[4:0];
            alu_op_pkg::SRL:                   r = a >> b[4:0];
            alu_op_pkg::SRA:                   r = (a >> b[4:0]) | fill;
            alu_op_pkg::SLT, alu_op_pkg::LT:   r = XW'(lt_s);
            alu_op_pkg::SLTU, alu_op_pkg::LTU: r = XW'(lt_u);
            alu_op_pkg::GE:                    r = XW'(!lt_s);
            alu_op_pkg::GEU:                   r = XW'(!lt_u);
            alu_op_pkg::EQ:                    r = XW'(a == b);
            alu_op_pkg::NE:                    r = XW'(a != b);
            default:                           r = '0;
        endcase
        return r;
    endfunction

    function automatic logic any_pending();
        logic busy;
        busy = 1'b0;
        for (int t = 1; t < NTAG; t++) begin
            busy = busy | pend[t];
        end
        return busy;
    endfunction

    task automatic resolve(input int t);
        if (!known[t] && wait_tag[t][0] == core_pkg::TAG_NONE &&
            wait_tag[t][1] == core_pkg::TAG_NONE) begin
            expect_v[t] = expected_result(pend_op[t], opnd[t][0], opnd[t][1]);
            known[t]    = 1'b1;
        end
    endtask

    task automatic wake(input logic [TW-1:0] bus_tag, input logic [XW-1:0] bus_value);
        for (int t = 1; t < NTAG; t++) begin
            for (int k = 0; k < 2; k++) begin
                if (pend[t] && wait_tag[t][k] != core_pkg::TAG_NONE &&
                    wait_tag[t][k] == bus_tag) begin
                    opnd[t][k]     = bus_value;
                    wait_tag[t][k] = core_pkg::TAG_NONE;
                end
            end
            resolve(t);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////

    task automatic check_tag(input logic [core_pkg::TAG_W-1:0] tag);
        checks++;
        if (tag == core_pkg::TAG_NONE) begin
            errors++;
            $display("result bus carries tag zero");
        end else if (!pend[tag]) begin
            errors++;
            $display("tag %0d broadcast while not in flight", tag);
        end else if (!known[tag]) begin
            errors++;
            $display("tag %0d broadcast before its operands arrived", tag);
        end
    endtask

    task automatic check_value(input logic [core_pkg::TAG_W-1:0] tag,
                               input logic [core_pkg::XLEN-1:0] got);
        checks++;
        if (got !== expect_v[tag]) begin
            errors++;
            $display("Mismatch cdb_value tag %0h: got %h, expected %h", tag, got, expect_v[tag]);
        end
    endtask

    task automatic check_full(input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch full: got %h, expected %h", got, want);
        end
    endtask

    // sampled before the edge updates, so it sees what the station sees.
    always @(posedge clk) begin
        if (rst) begin
            cycle = cycle + 1;
            if (cdb_valid) begin
                check_tag(cdb_tag);
                if (pend[cdb_tag] && known[cdb_tag]) begin
                    check_value(cdb_tag, cdb_value);
                    wake(cdb_tag, expect_v[cdb_tag]);   // consumers get the model value.
                end
                pend[cdb_tag]       = 1'b0;
                done_cycle[cdb_tag] = cycle - 1;   // bus was set one edge earlier.
            end
            if (ext_valid) begin
                wake(ext_tag, ext_value);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // stimulus tasks, each starts and ends on a falling edge
    ////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $finish;
    endtask

    task automatic dispatch(input logic [OW-1:0] op, input logic [TW-1:0] dest,
                            input logic [TW-1:0] t1, input logic [XW-1:0] v1,
                            input logic [TW-1:0] t2, input logic [XW-1:0] v2);
        int n;
        n = 0;
        while (full && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (full) begin
            abort_run("timeout: station stayed full before a dispatch");
        end else begin
            disp_valid      = 1'b1;
            disp_op         = op;
            disp_dest       = dest;
            disp_src1_tag   = t1;
            disp_src1_value = v1;
            disp_src2_tag   = t2;
            disp_src2_value = v2;
            if (dest != core_pkg::TAG_NONE) begin
                pend[dest]        = 1'b1;
                known[dest]       = 1'b0;
                pend_op[dest]     = op;
                wait_tag[dest][0] = t1;
                wait_tag[dest][1] = t2;
                opnd[dest][0]     = v1;
                opnd[dest][1]     = v2;
                disp_cycle[dest]  = cycle + 1;
                resolve(int'(dest));
            end
            @(negedge clk);
            disp_valid = 1'b0;
        end
    endtask

    task automatic send_ext(input logic [TW-1:0] tag, input logic [XW-1:0] value);
        ext_valid = 1'b1;
        ext_tag   = tag;
        ext_value = value;
        @(negedge clk);
        ext_valid = 1'b0;
    endtask

    task automatic pick_free_tag(output logic [TW-1:0] tag);
        int n;
        int start;
        n     = 0;
        start = int'($urandom() % (NTAG - 1));
        tag   = core_pkg::TAG_NONE;
        while (tag == core_pkg::TAG_NONE && n < LIMIT) begin
            for (int k = 0; k < NTAG - 1; k++) begin
                if (tag == core_pkg::TAG_NONE && !pend[1 + (start + k) % (NTAG - 1)]) begin
                    tag = TW'(1 + (start + k) % (NTAG - 1));
                end
            end
            if (tag == core_pkg::TAG_NONE) begin
                @(negedge clk);
                n++;
            end
        end
        if (tag == core_pkg::TAG_NONE) begin
            abort_run("timeout: no destination tag became free");
        end
    endtask

    task automatic wait_done(input logic [TW-1:0] tag);
        int n;
        n = 0;
        while (pend[tag] && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (pend[tag]) begin
            abort_run($sformatf("timeout: tag %0d never completed", tag));
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (any_pending() && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (any_pending()) begin
            abort_run("timeout: operations still in flight");
        end else begin
            repeat (6) @(negedge clk);   // untracked tag-zero entries drain.
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("test %s: %s, %0d errors", name, (errors == err0) ? "ok" : "FAILED",
                 errors - err0);
    endtask

    ////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        int            err0;
        int            j;
        logic [TW-1:0] t;
        logic [TW-1:0] prev;
        logic [TW-1:0] t1;
        logic [TW-1:0] t2;
        logic [TW-1:0] order [3];
        logic [XW-1:0] a;
        logic [XW-1:0] b;
        void'($urandom(32'h11437d5d));
        clk             = 1'b0;
        rst             = 1'b0;
        disp_valid      = 1'b0;
        disp_op         = '0;
        disp_dest       = '0;
        disp_src1_tag   = '0;
        disp_src1_value = '0;
        disp_src2_tag   = '0;
        disp_src2_value = '0;
        ext_valid       = 1'b0;
        ext_tag         = '0;
        ext_value       = '0;
        cycle           = 0;
        checks          = 0;
        errors          = 0;
        tests           = 0;
        for (int k = 0; k < NTAG; k++) begin
            pend[k]  = 1'b0;
            known[k] = 1'b0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b1;

        // every code, unused ones included, with ready operands.
        err0 = errors;
        for (int i = 0; i < 64; i++) begin
            pick_free_tag(t);
            a = $urandom();
            b = (i % 6 == 0) ? a : $urandom();
            dispatch(OW'(i % 32), t, core_pkg::TAG_NONE, a, core_pkg::TAG_NONE, b);
        end
        wait_idle();
        report_test("op_coverage", err0);

        err0 = errors;
        for (int i = 1; i < NTAG; i++) begin
            t = TW'(i);
            dispatch(OW'($urandom()), t, core_pkg::TAG_NONE, $urandom(),
                     core_pkg::TAG_NONE, $urandom());
            wait_done(t);
            checks++;
            if (done_cycle[t] - disp_cycle[t] != 2) begin
                errors++;
                $display("tag %0d reached the bus %0d cycles after dispatch instead of 2",
                         t, done_cycle[t] - disp_cycle[t]);
            end
        end
        report_test("ready_latency", err0);

        // tags 1 to 4 are produced here, 5 to 7 by outside units.
        err0 = errors;
        for (int r = 0; r < 6; r++) begin
            for (int i = 1; i <= 4; i++) begin
                t1 = ($urandom() % 3 == 0) ? core_pkg::TAG_NONE : TW'(5 + $urandom() % 3);
                t2 = ($urandom() % 3 == 0) ? core_pkg::TAG_NONE : TW'(5 + $urandom() % 3);
                dispatch(OW'($urandom()), TW'(i), t1, $urandom(), t2, $urandom());
            end
            repeat ($urandom() % 4) @(negedge clk);
            order[0] = TW'(5);
            order[1] = TW'(6);
            order[2] = TW'(7);
            for (int k = 2; k > 0; k--) begin
                j        = int'($urandom() % (k + 1));
                t        = order[k];
                order[k] = order[j];
                order[j] = t;
            end
            for (int k = 0; k < 3; k++) begin
                send_ext(order[k], $urandom());
                repeat ($urandom() % 3) @(negedge clk);
            end
            for (int i = 1; i <= 4; i++) begin
                wait_done(TW'(i));
            end
        end
        wait_idle();
        report_test("external_wakeup", err0);

        err0 = errors;
        for (int r = 0; r < 4; r++) begin
            prev = core_pkg::TAG_NONE;
            for (int i = 1; i < NTAG; i++) begin
                t1 = core_pkg::TAG_NONE;
                t2 = core_pkg::TAG_NONE;
                if ($urandom() % 2 == 0) begin
                    t1 = prev;
                end else begin
                    t2 = prev;
                end
                dispatch(OW'($urandom()), TW'(i), t1, $urandom(), t2, $urandom());
                prev = TW'(i);
            end
            wait_idle();
        end
        report_test("chained_dependency", err0);

        // all four entries wait on outside tags 6 and 7.
        err0 = errors;
        for (int r = 0; r < 4; r++) begin
            for (int i = 1; i <= 4; i++) begin
                t  = (r > 0 && $urandom() % 2 == 0) ? core_pkg::TAG_NONE : TW'(i);
                t2 = ($urandom() % 2 == 0) ? core_pkg::TAG_NONE : TW'(7);
                dispatch(OW'($urandom()), t, TW'(6), $urandom(), t2, $urandom());
            end
            check_full(full, 1'b1);
            t1 = TW'(6);
            t2 = TW'(7);
            if ($urandom() % 2 == 0) begin
                t1 = TW'(7);
                t2 = TW'(6);
            end
            send_ext(t1, $urandom());
            send_ext(t2, $urandom());
            wait_idle();
            check_full(full, 1'b0);
        end
        report_test("full_and_no_dest", err0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- alu_exec.f
rtl/core_pkg.sv
rtl/alu_op_pkg.sv
rtl/alu_station.sv
rtl/alu_datapath.sv
rtl/cdb_writer.sv
rtl/alu_exec_unit.sv
tests/alu_exec_props.sv
tests/tb_alu_exec.sv

//--- run.sh
#!/bin/sh
# Build the execution cluster testbench with Verilator and run it.
# The run fails on a build error, on the fail message in the log, or
# when the log holds no verdict at all.
rm -rf obj_dir sim.log build.log
verilator --binary --assert --top-module tb_alu_exec -f alu_exec.f > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }
./obj_dir/Vtb_alu_exec > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
